// ==== include/fabric_defs.svh ====
/*
 * Shared assertion helpers for the cluster fabric RTL
 * Clocking and reset qualifier used by every fabric check
 */
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

// Checks sample on the fabric clock and sleep during reset
`define FABRIC_CLK_RST @(posedge clk_i) disable iff (!rst_n_i)

`define FABRIC_ASSERT(name, prop) \
  name : assert property (`FABRIC_CLK_RST (prop)) \
    else $error("%m: fabric check failed");

`endif

// ==== rtl/cluster_fabric_pkg.sv ====
/*
 * Fabric configuration package
 * Cluster count, fork tree depth, request and ring word widths
 * Floorplan ring bypass masks
 */
`default_nettype none

package cluster_fabric_pkg;

  ////////////////////
  // Topology
  ////////////////////

  // Must stay a power of two, the fork tree is binary
  localparam int unsigned NR_CLUSTERS = 4;
  localparam int unsigned NR_LEVELS   = $clog2(NR_CLUSTERS);

  ////////////////////
  // Word widths
  ////////////////////

  localparam int unsigned REQ_WIDTH  = 32;
  localparam int unsigned RING_WIDTH = 64;

  ////////////////////
  // Ring floorplan
  ////////////////////

  // Set bit: hop leaving that cluster is abutted, no spill register
  localparam logic [NR_CLUSTERS-1:0] RING_BYPASS_LEFT  = 4'b0101;
  localparam logic [NR_CLUSTERS-1:0] RING_BYPASS_RIGHT = 4'b1010;

endpackage

`default_nettype wire

// ==== rtl/req_fork_node.sv ====
/*
 * Registered one-to-two stream fork
 * One word register plus a per-child owed flag
 * Input is released once both children have taken the word
 */
`default_nettype none

`include "fabric_defs.svh"

module req_fork_node (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Upstream side
  input  logic                                   valid_i,
  input  logic [cluster_fabric_pkg::REQ_WIDTH-1:0] data_i,
  output logic                                   ready_o,
  // Two children, same word
  output logic [1:0]                             valid_o,
  output logic [cluster_fabric_pkg::REQ_WIDTH-1:0] data_o,
  input  logic [1:0]                             ready_i
);

  import cluster_fabric_pkg::*;

  logic [REQ_WIDTH-1:0] data_q;
  logic [1:0]           owed_q;
  logic [1:0]           owed_next;
  logic                 accept;

  ////////////////////
  // Handshake
  ////////////////////

  // Children still waiting after this cycle's handshakes
  assign owed_next = owed_q & ~ready_i;

  // Free once nobody is left owed, also when the last child takes it now
  assign ready_o = ~|owed_next;
  assign accept  = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owed_q <= '0;
    end else if (accept) begin
      owed_q <= 2'b11;
    end else begin
      owed_q <= owed_next;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= data_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // A child sees valid until it has taken the word once
  assign valid_o = owed_q;
  assign data_o  = data_q;

  // Word held for a blocked child must not change under it
  `FABRIC_ASSERT(a_data_stable_while_owed, (|owed_next) |=> $stable(data_o))

endmodule

`default_nettype wire

// ==== rtl/req_broadcast_tree.sv ====
/*
 * Binary broadcast tree of registered fork nodes
 * Level l holds 2^l nodes, one cycle per level
 * Every leaf sees every root word once and in order
 */
`default_nettype none

module req_broadcast_tree (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Host request
  input  logic                                   req_valid_i,
  input  logic [cluster_fabric_pkg::REQ_WIDTH-1:0] req_data_i,
  output logic                                   req_ready_o,
  // Cluster leaves
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] leaf_valid_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::REQ_WIDTH-1:0]
                                                 leaf_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] leaf_ready_i
);

  import cluster_fabric_pkg::*;

  // Stream signals between levels, index 0 is the root
  logic [NR_LEVELS:0][NR_CLUSTERS-1:0]                lvl_valid;
  logic [NR_LEVELS:0][NR_CLUSTERS-1:0][REQ_WIDTH-1:0] lvl_data;
  logic [NR_LEVELS:0][NR_CLUSTERS-1:0]                lvl_ready;

  assign lvl_valid[0][0] = req_valid_i;
  assign lvl_data[0][0]  = req_data_i;
  assign req_ready_o     = lvl_ready[0][0];

  for (genvar l = 0; l < NR_LEVELS; l++) begin : g_level
    for (genvar n = 0; n < (1 << l); n++) begin : g_node
      logic [REQ_WIDTH-1:0] node_data;

      req_fork_node i_fork_node (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (lvl_valid[l][n]),
        .data_i  (lvl_data[l][n]),
        .ready_o (lvl_ready[l][n]),
        .valid_o (lvl_valid[l+1][2*n +: 2]),
        .data_o  (node_data),
        .ready_i (lvl_ready[l+1][2*n +: 2])
      );

      // Both children share the node register
      assign lvl_data[l+1][2*n]   = node_data;
      assign lvl_data[l+1][2*n+1] = node_data;
    end

    // Slots past the width of this level carry nothing
    for (genvar n = (1 << l); n < NR_CLUSTERS; n++) begin : g_unused
      assign lvl_valid[l][n] = 1'b0;
      assign lvl_data[l][n]  = '0;
      assign lvl_ready[l][n] = 1'b0;
    end
  end

  assign leaf_valid_o         = lvl_valid[NR_LEVELS];
  assign leaf_data_o          = lvl_data[NR_LEVELS];
  assign lvl_ready[NR_LEVELS] = leaf_ready_i;

endmodule

`default_nettype wire

// ==== rtl/ring_spill_reg.sv ====
/*
 * Two-slot spill register for one ring hop
 * Ready toward the sender depends on flops only
 * One cycle latency, one word per cycle
 */
`default_nettype none

`include "fabric_defs.svh"

module ring_spill_reg (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    valid_i,
  input  logic [cluster_fabric_pkg::RING_WIDTH-1:0] data_i,
  output logic                                    ready_o,
  output logic                                    valid_o,
  output logic [cluster_fabric_pkg::RING_WIDTH-1:0] data_o,
  input  logic                                    ready_i
);

  import cluster_fabric_pkg::*;

  logic [RING_WIDTH-1:0] a_data_q;
  logic [RING_WIDTH-1:0] b_data_q;
  logic                  a_full_q;
  logic                  b_full_q;
  logic                  a_fill;
  logic                  a_drain;
  logic                  b_fill;
  logic                  b_drain;

  ////////////////////
  // Slot A, input side
  ////////////////////

  assign a_fill  = valid_i & ready_o;
  // A empties whenever B has room, either out or into B
  assign a_drain = a_full_q & ~b_full_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
    end else if (a_fill || a_drain) begin
      a_full_q <= a_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
  end

  ////////////////////
  // Slot B, overflow
  ////////////////////

  // Catches A only when the receiver stalls
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_full_q <= 1'b0;
    end else if (b_fill || b_drain) begin
      b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older word sits in B when both are full
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = ~a_full_q | ~b_full_q;

  // No word may land in A while both slots hold data
  `FABRIC_ASSERT(a_no_accept_when_full, (a_full_q && b_full_q) |-> !a_fill)

endmodule

`default_nettype wire

// ==== rtl/ring_network.sv ====
/*
 * Bidirectional cluster ring
 * Right hops go c to c+1, left hops go c to c-1, with wrap
 * Each hop is a spill register or plain wires, per floorplan mask
 */
`default_nettype none

module ring_network (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // Toward the right neighbour
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_valid_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_r_data_i,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_ready_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_valid_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_r_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_ready_i,
  // Toward the left neighbour
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_valid_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_l_data_i,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_ready_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_valid_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_l_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_ready_i
);

  import cluster_fabric_pkg::*;

  for (genvar c = 0; c < NR_CLUSTERS; c++) begin : g_hop
    // Neighbour indices with wrap-around
    localparam int unsigned NXT = (c + 1) % NR_CLUSTERS;
    localparam int unsigned PRV = (c + NR_CLUSTERS - 1) % NR_CLUSTERS;

    ////////////////////
    // Right hop c -> NXT
    ////////////////////
    if (RING_BYPASS_RIGHT[c]) begin : g_right_wire
      // Abutted macros, zero-cycle hop
      assign ring_r_valid_o[NXT] = ring_r_valid_i[c];
      assign ring_r_data_o[NXT]  = ring_r_data_i[c];
      assign ring_r_ready_o[c]   = ring_r_ready_i[NXT];
    end else begin : g_right_cut
      ring_spill_reg i_spill_right (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (ring_r_valid_i[c]),
        .data_i  (ring_r_data_i[c]),
        .ready_o (ring_r_ready_o[c]),
        .valid_o (ring_r_valid_o[NXT]),
        .data_o  (ring_r_data_o[NXT]),
        .ready_i (ring_r_ready_i[NXT])
      );
    end

    ////////////////////
    // Left hop c -> PRV
    ////////////////////
    if (RING_BYPASS_LEFT[c]) begin : g_left_wire
      assign ring_l_valid_o[PRV] = ring_l_valid_i[c];
      assign ring_l_data_o[PRV]  = ring_l_data_i[c];
      assign ring_l_ready_o[c]   = ring_l_ready_i[PRV];
    end else begin : g_left_cut
      ring_spill_reg i_spill_left (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (ring_l_valid_i[c]),
        .data_i  (ring_l_data_i[c]),
        .ready_o (ring_l_ready_o[c]),
        .valid_o (ring_l_valid_o[PRV]),
        .data_o  (ring_l_data_o[PRV]),
        .ready_i (ring_l_ready_i[PRV])
      );
    end
  end

endmodule

`default_nettype wire

// ==== rtl/idx_sync.sv ====
/*
 * Indexed-operation barrier
 * Sticky completion vectors from clusters and from the shuffle side
 * One-cycle sync pulse when both match, then both clear
 */
`default_nettype none

`include "fabric_defs.svh"

module idx_sync (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] idx_done_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] shuf_done_i,
  output logic                                     idx_sync_o
);

  import cluster_fabric_pkg::*;

  logic [NR_CLUSTERS-1:0] idx_seen_q;
  logic [NR_CLUSTERS-1:0] shuf_seen_q;
  logic                   sync_all;

  // Both sides reported and agree on the cluster set
  assign sync_all = (idx_seen_q != '0) && (shuf_seen_q != '0) &&
                    (idx_seen_q == shuf_seen_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idx_seen_q  <= '0;
      shuf_seen_q <= '0;
    end else if (sync_all) begin
      // Round closes, pulses landing in this cycle are dropped
      idx_seen_q  <= '0;
      shuf_seen_q <= '0;
    end else begin
      idx_seen_q  <= idx_seen_q | idx_done_i;
      shuf_seen_q <= shuf_seen_q | shuf_done_i;
    end
  end

  assign idx_sync_o = sync_all;

  // Clear after a match leaves a gap of at least one cycle
  `FABRIC_ASSERT(a_sync_single_cycle, idx_sync_o |=> !idx_sync_o)

endmodule

`default_nettype wire

// ==== rtl/cluster_fabric.sv ====
/*
 * Inter-cluster fabric top
 * Request broadcast tree, bidirectional ring, indexed barrier
 */
`default_nettype none

module cluster_fabric (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // Host request
  input  logic                                     req_valid_i,
  input  logic [cluster_fabric_pkg::REQ_WIDTH-1:0]   req_data_i,
  output logic                                     req_ready_o,
  // Request leaves, one per cluster
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] leaf_valid_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::REQ_WIDTH-1:0]
                                                   leaf_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] leaf_ready_i,
  // Ring, right direction
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_valid_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_r_data_i,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_ready_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_valid_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_r_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_ready_i,
  // Ring, left direction
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_valid_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_l_data_i,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_ready_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_valid_o,
  output logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                   ring_l_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_ready_i,
  // Indexed barrier
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] idx_done_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] shuf_done_i,
  output logic                                     idx_sync_o
);

  // Host request fan-out
  req_broadcast_tree i_req_tree (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_data_i   (req_data_i),
    .req_ready_o  (req_ready_o),
    .leaf_valid_o (leaf_valid_o),
    .leaf_data_o  (leaf_data_o),
    .leaf_ready_i (leaf_ready_i)
  );

  ring_network i_ring (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ring_r_valid_i (ring_r_valid_i),
    .ring_r_data_i  (ring_r_data_i),
    .ring_r_ready_o (ring_r_ready_o),
    .ring_r_valid_o (ring_r_valid_o),
    .ring_r_data_o  (ring_r_data_o),
    .ring_r_ready_i (ring_r_ready_i),
    .ring_l_valid_i (ring_l_valid_i),
    .ring_l_data_i  (ring_l_data_i),
    .ring_l_ready_o (ring_l_ready_o),
    .ring_l_valid_o (ring_l_valid_o),
    .ring_l_data_o  (ring_l_data_o),
    .ring_l_ready_i (ring_l_ready_i)
  );

  idx_sync i_idx_sync (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .idx_done_i  (idx_done_i),
    .shuf_done_i (shuf_done_i),
    .idx_sync_o  (idx_sync_o)
  );

endmodule

`default_nettype wire

// ==== verification/fabric_checker.sv ====
/*
 * Fabric checker
 * Expected-word queues per leaf and per ring port, built from the root and ring inputs
 * Latency checks, barrier model, reset values, error counters
 */
`default_nettype none

module fabric_checker (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic [127:0]                               test_name_i,
  input  logic                                       strict_i,
  input  logic                                       req_valid_i,
  input  logic [cluster_fabric_pkg::REQ_WIDTH-1:0]   req_data_i,
  input  logic                                       req_ready_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] leaf_valid_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::REQ_WIDTH-1:0]
                                                     leaf_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] leaf_ready_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_valid_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                     ring_r_data_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_ready_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_valid_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                     ring_r_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_r_ready_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_valid_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                     ring_l_data_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_ready_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_valid_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0][cluster_fabric_pkg::RING_WIDTH-1:0]
                                                     ring_l_data_o,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] ring_l_ready_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] idx_done_i,
  input  logic [cluster_fabric_pkg::NR_CLUSTERS-1:0] shuf_done_i,
  input  logic                                       idx_sync_o,
  output int                                         val_errs_o,
  output int                                         oth_errs_o,
  output int                                         pending_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import cluster_fabric_pkg::*;

  localparam int N  = NR_CLUSTERS;
  localparam int QD = 64;
  // Queues 0..N-1 leaves, N..2N-1 right ring ports, 2N..3N-1 left ring ports
  localparam int NQ = 3 * N;

  logic [63:0]    exp_q   [NQ][QD];
  int             exp_t   [NQ][QD];
  int             wr_ptr  [NQ];
  int             rd_ptr  [NQ];
  int             cyc;
  int             rst_edges;
  logic [N-1:0]   m_idx;
  logic [N-1:0]   m_shuf;
  logic           exp_sync;

  task automatic push_word(input int qi, input logic [63:0] data);
    exp_q[qi][wr_ptr[qi] % QD] = data;
    exp_t[qi][wr_ptr[qi] % QD] = cyc;
    wr_ptr[qi]++;
  endtask

  task automatic pop_word(input int qi, input logic [63:0] data, input int lat);
    string where;
    logic [63:0] exp_d;
    int t;
    where = (qi < N) ? "leaf" : ((qi < 2 * N) ? "ring right port" : "ring left port");
    if (wr_ptr[qi] == rd_ptr[qi]) begin
      $display("%0s: %0s %0d delivered a word that was never sent", test_name_i, where, qi % N);
      oth_errs_o++;
    end else begin
      exp_d = exp_q[qi][rd_ptr[qi] % QD];
      t     = exp_t[qi][rd_ptr[qi] % QD];
      rd_ptr[qi]++;
      if (data !== exp_d) begin
        $display("FAIL %0s: %0s %0d word expected %h actual %h",
                 test_name_i, where, qi % N, exp_d, data);
        val_errs_o++;
      end
      if (strict_i && (cyc - t != lat)) begin
        $display("FAIL %0s: %0s %0d latency expected %0d actual %0d",
                 test_name_i, where, qi % N, lat, cyc - t);
        val_errs_o++;
      end
    end
  endtask

  always_comb begin
    pending_o = 0;
    for (int q = 0; q < NQ; q++) begin
      pending_o += wr_ptr[q] - rd_ptr[q];
    end
  end

  initial begin
    val_errs_o = 0;
    oth_errs_o = 0;
    cyc        = 0;
    rst_edges  = 0;
    for (int q = 0; q < NQ; q++) begin
      wr_ptr[q] = 0;
      rd_ptr[q] = 0;
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_edges++;
      m_idx  = '0;
      m_shuf = '0;
      // First edge only loads the reset, outputs settle after it
      if (rst_edges >= 2) begin
        if (req_ready_o !== 1'b1 || leaf_valid_o !== '0 || ring_r_valid_o !== '0 ||
            ring_l_valid_o !== '0 || idx_sync_o !== 1'b0) begin
          // Fields: req ready, leaf valid, right valid, left valid, sync
          $display("FAIL %0s: reset outputs expected %b_%h_%h_%h_%b actual %b_%h_%h_%h_%b",
                   test_name_i, 1'b1, {N{1'b0}}, {N{1'b0}}, {N{1'b0}}, 1'b0,
                   req_ready_o, leaf_valid_o, ring_r_valid_o, ring_l_valid_o, idx_sync_o);
          val_errs_o++;
        end
      end
    end else begin
      cyc++;

      ////////////////////
      // Expected words
      ////////////////////
      if (req_valid_i && req_ready_o) begin
        for (int c = 0; c < N; c++) begin
          push_word(c, 64'(req_data_i));
        end
      end
      for (int c = 0; c < N; c++) begin
        if (ring_r_valid_i[c] && ring_r_ready_o[c]) begin
          push_word(N + (c + 1) % N, ring_r_data_i[c]);
        end
        if (ring_l_valid_i[c] && ring_l_ready_o[c]) begin
          push_word(2 * N + (c + N - 1) % N, ring_l_data_i[c]);
        end
      end

      ////////////////////
      // Delivered words
      ////////////////////
      for (int c = 0; c < N; c++) begin
        if (leaf_valid_o[c] && leaf_ready_i[c]) begin
          pop_word(c, 64'(leaf_data_o[c]), int'(NR_LEVELS));
        end
        // Cut hop one cycle, abutted hop none
        if (ring_r_valid_o[c] && ring_r_ready_i[c]) begin
          pop_word(N + c, ring_r_data_o[c], RING_BYPASS_RIGHT[(c + N - 1) % N] ? 0 : 1);
        end
        if (ring_l_valid_o[c] && ring_l_ready_i[c]) begin
          pop_word(2 * N + c, ring_l_data_o[c], RING_BYPASS_LEFT[(c + 1) % N] ? 0 : 1);
        end
      end

      ////////////////////
      // Barrier
      ////////////////////
      exp_sync = (m_idx != '0) && (m_shuf != '0) && (m_idx == m_shuf);
      if (idx_sync_o !== exp_sync) begin
        $display("FAIL %0s: idx_sync_o expected %b actual %b", test_name_i, exp_sync, idx_sync_o);
        val_errs_o++;
      end
      if (exp_sync) begin
        m_idx  = '0;
        m_shuf = '0;
      end else begin
        m_idx  = m_idx | idx_done_i;
        m_shuf = m_shuf | shuf_done_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_cluster_fabric.sv ====
/*
 * Cluster fabric testbench
 * Clock, reset, test table and driving loop
 * Random back-pressure, watchdog, DUT and checker instances
 */
`default_nettype none

module tb_cluster_fabric;

  timeunit 1ns;
  timeprecision 1ps;

  import cluster_fabric_pkg::*;

  localparam int NR_ROWS = 13;
  localparam int BURST   = 4;
  localparam int K_BCAST  = 0;
  localparam int K_RING_R = 1;
  localparam int K_RING_L = 2;
  localparam int K_SYNC   = 3;

  logic                                    clk_i;
  logic                                    rst_n_i;
  logic                                    req_valid_i;
  logic [REQ_WIDTH-1:0]                    req_data_i;
  logic                                    req_ready_o;
  logic [NR_CLUSTERS-1:0]                  leaf_valid_o;
  logic [NR_CLUSTERS-1:0][REQ_WIDTH-1:0]   leaf_data_o;
  logic [NR_CLUSTERS-1:0]                  leaf_ready_i;
  logic [NR_CLUSTERS-1:0]                  ring_r_valid_i;
  logic [NR_CLUSTERS-1:0][RING_WIDTH-1:0]  ring_r_data_i;
  logic [NR_CLUSTERS-1:0]                  ring_r_ready_o;
  logic [NR_CLUSTERS-1:0]                  ring_r_valid_o;
  logic [NR_CLUSTERS-1:0][RING_WIDTH-1:0]  ring_r_data_o;
  logic [NR_CLUSTERS-1:0]                  ring_r_ready_i;
  logic [NR_CLUSTERS-1:0]                  ring_l_valid_i;
  logic [NR_CLUSTERS-1:0][RING_WIDTH-1:0]  ring_l_data_i;
  logic [NR_CLUSTERS-1:0]                  ring_l_ready_o;
  logic [NR_CLUSTERS-1:0]                  ring_l_valid_o;
  logic [NR_CLUSTERS-1:0][RING_WIDTH-1:0]  ring_l_data_o;
  logic [NR_CLUSTERS-1:0]                  ring_l_ready_i;
  logic [NR_CLUSTERS-1:0]                  idx_done_i;
  logic [NR_CLUSTERS-1:0]                  shuf_done_i;
  logic                                    idx_sync_o;

  // Test table, barrier rows carry idx set in [3:0] and shuffle set in [7:4]
  logic [127:0]   row_name [NR_ROWS];
  int             row_kind [NR_ROWS];
  int             row_src  [NR_ROWS];
  logic [31:0]    row_data [NR_ROWS];
  logic           row_bp   [NR_ROWS];

  logic [127:0]   cur_name;
  logic           bp_mode;
  int             seed;
  int             val_errs;
  int             oth_errs;
  int             pending;
  int             total_errs;

  cluster_fabric UUT (.*);

  fabric_checker i_checker (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .test_name_i (cur_name), .strict_i (!bp_mode),
    .req_valid_i (req_valid_i), .req_data_i (req_data_i), .req_ready_o (req_ready_o),
    .leaf_valid_o (leaf_valid_o), .leaf_data_o (leaf_data_o), .leaf_ready_i (leaf_ready_i),
    .ring_r_valid_i (ring_r_valid_i), .ring_r_data_i (ring_r_data_i),
    .ring_r_ready_o (ring_r_ready_o), .ring_r_valid_o (ring_r_valid_o),
    .ring_r_data_o (ring_r_data_o), .ring_r_ready_i (ring_r_ready_i),
    .ring_l_valid_i (ring_l_valid_i), .ring_l_data_i (ring_l_data_i),
    .ring_l_ready_o (ring_l_ready_o), .ring_l_valid_o (ring_l_valid_o),
    .ring_l_data_o (ring_l_data_o), .ring_l_ready_i (ring_l_ready_i),
    .idx_done_i (idx_done_i), .shuf_done_i (shuf_done_i), .idx_sync_o (idx_sync_o),
    .val_errs_o (val_errs), .oth_errs_o (oth_errs), .pending_o (pending)
  );

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    repeat (NR_ROWS * 50) @(posedge clk_i);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Receiver readiness, each port ready three cycles in four under back-pressure
  always @(posedge clk_i) begin
    for (int c = 0; c < NR_CLUSTERS; c++) begin
      leaf_ready_i[c]   <= bp_mode ? (($random(seed) & 3) != 0) : 1'b1;
      ring_r_ready_i[c] <= bp_mode ? (($random(seed) & 3) != 0) : 1'b1;
      ring_l_ready_i[c] <= bp_mode ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  task automatic set_row(input int r, input logic [127:0] name, input int kind,
                         input int src, input logic [31:0] data, input logic bp);
    row_name[r] = name;
    row_kind[r] = kind;
    row_src[r]  = src;
    row_data[r] = data;
    row_bp[r]   = bp;
  endtask

  task automatic drive_word(input int r, input int i);
    int c;
    c = row_src[r];
    case (row_kind[r])
      K_BCAST: begin
        req_valid_i <= 1'b1;
        req_data_i  <= row_data[r] + 32'(i);
      end
      K_RING_R: begin
        ring_r_valid_i[c] <= 1'b1;
        ring_r_data_i[c]  <= {row_data[r], 32'(i)};
      end
      default: begin
        ring_l_valid_i[c] <= 1'b1;
        ring_l_data_i[c]  <= {row_data[r], 32'(i)};
      end
    endcase
  endtask

  function automatic logic port_ready(input int r);
    case (row_kind[r])
      K_BCAST:  return req_ready_o;
      K_RING_R: return ring_r_ready_o[row_src[r]];
      default:  return ring_l_ready_o[row_src[r]];
    endcase
  endfunction

  task automatic send_burst(input int r);
    @(posedge clk_i);
    for (int i = 0; i < BURST; i++) begin
      drive_word(r, i);
      @(posedge clk_i);
      while (!port_ready(r)) @(posedge clk_i);
    end
    req_valid_i    <= 1'b0;
    ring_r_valid_i <= '0;
    ring_l_valid_i <= '0;
    // From the next edge on every accepted word sits in the checker queues
    @(posedge clk_i);
    while (pending != 0) @(posedge clk_i);
  endtask

  task automatic pulse_sets(input logic [31:0] sets);
    for (int c = 0; c < NR_CLUSTERS; c++) begin
      if (sets[c]) begin
        @(posedge clk_i);
        idx_done_i    <= '0;
        idx_done_i[c] <= 1'b1;
      end
    end
    @(posedge clk_i);
    idx_done_i <= '0;
    for (int c = 0; c < NR_CLUSTERS; c++) begin
      if (sets[4 + c]) begin
        @(posedge clk_i);
        shuf_done_i    <= '0;
        shuf_done_i[c] <= 1'b1;
      end
    end
    @(posedge clk_i);
    shuf_done_i <= '0;
    repeat (3) @(posedge clk_i);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed           = 97347;
    rst_n_i        = 1'b0;
    bp_mode        = 1'b0;
    cur_name       = 128'("reset");
    req_valid_i    = 1'b0;
    req_data_i     = '0;
    leaf_ready_i   = '1;
    ring_r_valid_i = '0;
    ring_r_data_i  = '0;
    ring_r_ready_i = '1;
    ring_l_valid_i = '0;
    ring_l_data_i  = '0;
    ring_l_ready_i = '1;
    idx_done_i     = '0;
    shuf_done_i    = '0;

    set_row(0,  128'("bcast_plain"),  K_BCAST,  0, 32'h1000_0001, 1'b0);
    set_row(1,  128'("bcast_bp"),     K_BCAST,  0, 32'hA5A5_0000, 1'b1);
    set_row(2,  128'("ring_r_c0"),    K_RING_R, 0, 32'hC0DE_0000, 1'b0);
    set_row(3,  128'("ring_r_c1"),    K_RING_R, 1, 32'hC1DE_0000, 1'b0);
    set_row(4,  128'("ring_r_c3_bp"), K_RING_R, 3, 32'hC3DE_0000, 1'b1);
    set_row(5,  128'("ring_l_c0"),    K_RING_L, 0, 32'hB0B0_0000, 1'b0);
    set_row(6,  128'("ring_l_c1_bp"), K_RING_L, 1, 32'hB1B1_0000, 1'b1);
    set_row(7,  128'("ring_l_c2_bp"), K_RING_L, 2, 32'hB2B2_0000, 1'b1);
    set_row(8,  128'("sync_equal"),   K_SYNC,   0, 32'h0000_0055, 1'b0);
    set_row(9,  128'("sync_unequal"), K_SYNC,   0, 32'h0000_0013, 1'b0);
    set_row(10, 128'("sync_finish"),  K_SYNC,   0, 32'h0000_0020, 1'b0);
    set_row(11, 128'("bcast_bp2"),    K_BCAST,  0, 32'h7E57_0000, 1'b1);
    set_row(12, 128'("ring_r_c2_bp"), K_RING_R, 2, 32'hC2DE_0000, 1'b1);

    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int r = 0; r < NR_ROWS; r++) begin
      @(posedge clk_i);
      cur_name <= row_name[r];
      bp_mode  <= row_bp[r];
      // Let readiness follow the new mode before the first word
      repeat (2) @(posedge clk_i);
      if (row_kind[r] == K_SYNC) begin
        pulse_sets(row_data[r]);
      end else begin
        send_burst(r);
      end
    end

    bp_mode <= 1'b0;
    repeat (5) @(posedge clk_i);
    total_errs = val_errs + oth_errs;
    if (pending != 0) begin
      $display("%0d expected words never arrived", pending);
      total_errs++;
    end
    $display("Errors: %0d value mismatches, %0d other", val_errs, total_errs - val_errs);
    if (total_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/cluster_fabric_pkg.sv
rtl/req_fork_node.sv
rtl/req_broadcast_tree.sv
rtl/ring_spill_reg.sv
rtl/ring_network.sv
rtl/idx_sync.sv
rtl/cluster_fabric.sv
verification/fabric_checker.sv
verification/tb_cluster_fabric.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cluster fabric simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_cluster_fabric -o sim_fabric > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_fabric > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
